/* Makefile */
SIM       := verilator
FLAGS     := --binary --timing --assert
TOP       := load_store_unit_tb
FILELIST  := load_store_unit.f
RUN_FLAGS := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP), log to $(LOG), check for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* load_store_unit.f */
source/lsu_pkg.sv
source/lsu_request.sv
source/lsu_byte_lane.sv
source/lsu_load_align.sv
source/lsu_bus_ctrl.sv
source/load_store_unit.sv
verif/load_store_unit_chk.sv
verif/load_store_unit_tb.sv

/* source/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              req,
    input  wire lsu_req_t          req_data,
    output logic                   ack,
    output lsu_resp_t              resp,
    output mem_cmd_t               mem,
    input  wire logic [data_w-1:0] mem_readdata,
    input  wire logic              waitrequest
);

    lsu_req_t              cur;
    logic [data_w-1:0]     word_addr;
    logic [1:0]            addr_lo;
    logic [lanes-1:0]      byteenable;
    lane_ctl_t [lanes-1:0] lane_ctl;
    logic [data_w-1:0]     wbytes;
    logic [data_w-1:0]     rbytes;
    logic                  load_req;
    logic                  capture;
    logic                  finish;
    logic                  is_store;
    logic                  is_mem;

    assign is_store = cur.op inside {op_sb, op_sh, op_sw};
    assign is_mem   = !(cur.op inside {op_lui, op_none});

    lsu_request i_request (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_req   (load_req),
        .req_data   (req_data),
        .cur        (cur),
        .word_addr  (word_addr),
        .addr_lo    (addr_lo),
        .byteenable (byteenable),
        .lane_ctl   (lane_ctl)
    );

    // Lane g carries bits 8g+7:8g
    for (genvar g = 0; g < lanes; g++) begin : g_lane
        lsu_byte_lane i_byte_lane (
            .clk           (clk),
            .rst_n         (rst_n),
            .ctl           (lane_ctl[g]),
            .rt_data       (cur.rt_data),
            .readdata_byte (mem_readdata[8*g +: 8]),
            .capture       (capture),
            .wbyte         (wbytes[8*g +: 8]),
            .rbyte         (rbytes[8*g +: 8])
        );
    end

    lsu_load_align i_load_align (
        .clk     (clk),
        .rst_n   (rst_n),
        .cur     (cur),
        .addr_lo (addr_lo),
        .rbytes  (rbytes),
        .finish  (finish),
        .resp    (resp)
    );

    lsu_bus_ctrl i_bus_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .is_store    (is_store),
        .is_mem      (is_mem),
        .waitrequest (waitrequest),
        .load_req    (load_req),
        .capture     (capture),
        .finish      (finish),
        .read        (mem.read),
        .write       (mem.write),
        .ack         (ack)
    );

    assign mem.address    = word_addr;
    assign mem.byteenable = byteenable;
    assign mem.writedata  = wbytes;

endmodule

`default_nettype wire

/* source/lsu_bus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_ctrl (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic req,
    input  wire logic is_store,
    input  wire logic is_mem,
    input  wire logic waitrequest,
    output logic      load_req,
    output logic      capture,
    output logic      finish,
    output logic      read,
    output logic      write,
    output logic      ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_command,
        st_respond,
        st_hold_ack
    } state_e;

    state_e state;
    state_e state_nxt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        load_req  = 1'b0;
        capture   = 1'b0;
        finish    = 1'b0;
        read      = 1'b0;
        write     = 1'b0;
        ack       = 1'b0;
        case (state)
            st_idle: begin
                load_req = req;  // Register the request on the same edge
                if (req) begin
                    state_nxt = st_command;
                end
            end
            st_command: begin
                // Held until waitrequest drops
                read  = is_mem && !is_store;
                write = is_mem && is_store;
                if (!is_mem) begin
                    state_nxt = st_respond;  // lui skips the bus
                end else if (!waitrequest) begin
                    capture   = !is_store;   // readdata valid in this cycle
                    state_nxt = st_respond;
                end
            end
            st_respond: begin
                finish    = 1'b1;
                state_nxt = st_hold_ack;
            end
            st_hold_ack: begin
                ack = 1'b1;
                if (!req) begin
                    state_nxt = st_idle;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/lsu_byte_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_byte_lane
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire lane_ctl_t         ctl,
    input  wire logic [data_w-1:0] rt_data,
    input  wire logic [7:0]        readdata_byte,
    input  wire logic              capture,
    output logic [7:0]             wbyte,
    output logic [7:0]             rbyte
);

    // Store side
    always_comb begin
        wbyte = 8'h00;
        if (ctl.en) begin
            case (ctl.src)
                2'd0: wbyte = rt_data[7:0];
                2'd1: wbyte = rt_data[15:8];
                2'd2: wbyte = rt_data[23:16];
                2'd3: wbyte = rt_data[31:24];
            endcase
        end
    end

    // Load side, taken at the accepting edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rbyte <= 8'h00;
        end else if (capture) begin
            rbyte <= readdata_byte;
        end
    end

endmodule

`default_nettype wire

/* source/lsu_load_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
    import lsu_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire lsu_req_t          cur,
    input  wire logic [1:0]        addr_lo,
    input  wire logic [data_w-1:0] rbytes,
    input  wire logic              finish,
    output lsu_resp_t              resp
);

    logic [7:0]        sel_byte;
    logic [15:0]       sel_half;
    logic [data_w-1:0] rt_old;
    logic [data_w-1:0] wdata;
    logic              writes_reg;

    assign rt_old = cur.rt_data;

    // Byte and halfword picked by address offset
    always_comb begin
        case (addr_lo)
            2'b00: sel_byte = rbytes[31:24];
            2'b01: sel_byte = rbytes[23:16];
            2'b10: sel_byte = rbytes[15:8];
            2'b11: sel_byte = rbytes[7:0];
        endcase
        sel_half = addr_lo[1] ? rbytes[15:0] : rbytes[31:16];
    end

    always_comb begin
        wdata      = '0;
        writes_reg = 1'b1;
        case (cur.op)
            op_lb:  wdata = {{24{sel_byte[7]}}, sel_byte};
            op_lbu: wdata = {24'h000000, sel_byte};
            op_lh:  wdata = {{16{sel_half[15]}}, sel_half};
            op_lhu: wdata = {16'h0000, sel_half};
            op_lw:  wdata = rbytes;
            op_lwl: begin
                // Memory bytes fill from the top, rt keeps the rest
                case (addr_lo)
                    2'b00: wdata = rbytes;
                    2'b01: wdata = {rbytes[23:0], rt_old[7:0]};
                    2'b10: wdata = {rbytes[15:0], rt_old[15:0]};
                    2'b11: wdata = {rbytes[7:0], rt_old[23:0]};
                endcase
            end
            op_lwr: begin
                // Memory bytes fill from the bottom
                case (addr_lo)
                    2'b00: wdata = {rt_old[31:8], rbytes[31:24]};
                    2'b01: wdata = {rt_old[31:16], rbytes[31:16]};
                    2'b10: wdata = {rt_old[31:24], rbytes[31:8]};
                    2'b11: wdata = rbytes;
                endcase
            end
            op_lui: wdata = {cur.offset, 16'h0000};  // No bus access
            default: writes_reg = 1'b0;  // Stores and none
        endcase
    end

    // Held until the next operation finishes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp <= '0;
        end else if (finish) begin
            resp.reg_we <= writes_reg;
            resp.rt     <= cur.rt;
            resp.wdata  <= wdata;
        end
    end

endmodule

`default_nettype wire

/* source/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    localparam int data_w = 32;   // Core and bus word width
    localparam int lanes  = 4;    // Byte lanes per word

    // Memory operations handed over by the execute stage
    typedef enum logic [3:0] {
        op_none,
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_lwl,
        op_lwr,
        op_lui,
        op_sb,
        op_sh,
        op_sw
    } lsu_op_e;

    // Held stable by the core while req is high
    typedef struct packed {
        lsu_op_e           op;
        logic [4:0]        rt;
        logic [15:0]       offset;
        logic [data_w-1:0] base;     // rs value
        logic [data_w-1:0] rt_data;  // Store data, or old rt for lwl/lwr
    } lsu_req_t;

    // Register file write-back
    typedef struct packed {
        logic              reg_we;
        logic [4:0]        rt;
        logic [data_w-1:0] wdata;
    } lsu_resp_t;

    // Avalon command, address is always word aligned
    typedef struct packed {
        logic [data_w-1:0] address;
        logic [lanes-1:0]  byteenable;  // Bit 3 is address offset 0
        logic [data_w-1:0] writedata;
        logic              read;
        logic              write;
    } mem_cmd_t;

    typedef struct packed {
        logic       en;   // Lane written by a store
        logic [1:0] src;  // rt_data byte placed on the lane
    } lane_ctl_t;

endpackage

`default_nettype wire

/* source/lsu_request.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_request
    import lsu_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   load_req,
    input  wire lsu_req_t               req_data,
    output lsu_req_t                    cur,
    output logic [data_w-1:0]           word_addr,
    output logic [1:0]                  addr_lo,
    output logic [lanes-1:0]            byteenable,
    output lane_ctl_t [lanes-1:0]       lane_ctl
);

    logic [data_w-1:0] offset_ext;
    logic [data_w-1:0] eff_addr;
    logic              store_op;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur <= '0;  // op_none
        end else if (load_req) begin
            cur <= req_data;
        end
    end

    assign offset_ext = {{16{cur.offset[15]}}, cur.offset};
    assign eff_addr   = cur.base + offset_ext;
    assign word_addr  = {eff_addr[data_w-1:2], 2'b00};
    assign addr_lo    = eff_addr[1:0];

    // Big-endian enables, offset 0 maps to bit 3
    always_comb begin
        byteenable = 4'b0000;
        store_op   = 1'b0;
        case (cur.op)
            op_lw: byteenable = 4'b1111;
            op_sw: begin
                byteenable = 4'b1111;
                store_op   = 1'b1;
            end
            op_lb, op_lbu: byteenable = 4'b1000 >> addr_lo;
            op_sb: begin
                byteenable = 4'b1000 >> addr_lo;
                store_op   = 1'b1;
            end
            op_lh, op_lhu: byteenable = addr_lo[1] ? 4'b0011 : 4'b1100;  // addr_lo[0] ignored
            op_sh: begin
                byteenable = addr_lo[1] ? 4'b0011 : 4'b1100;
                store_op   = 1'b1;
            end
            op_lwl: byteenable = 4'b1111 >> addr_lo;  // From offset to end of word
            op_lwr: begin
                // From start of word up to offset
                case (addr_lo)
                    2'b00: byteenable = 4'b1000;
                    2'b01: byteenable = 4'b1100;
                    2'b10: byteenable = 4'b1110;
                    2'b11: byteenable = 4'b1111;
                endcase
            end
            default: byteenable = 4'b0000;  // lui and none stay off the bus
        endcase
    end

    // Store byte steering per lane
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            lane_ctl[i].en = store_op && byteenable[i];
            case (cur.op)
                op_sb:   lane_ctl[i].src = 2'd0;           // rt[7:0] on the selected lane
                op_sh:   lane_ctl[i].src = {1'b0, i[0]};   // Upper lane of a pair gets rt[15:8]
                default: lane_ctl[i].src = 2'(i);          // sw keeps byte order
            endcase
        end
    end

endmodule

`default_nettype wire

/* verif/load_store_unit_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit_chk
    import lsu_pkg::*;
(
    input wire logic     clk,
    input wire logic     rst_n,
    input wire logic     req,
    input wire logic     ack,
    input wire logic     waitrequest,
    input wire mem_cmd_t mem
);

    int fail_count = 0;  // Read by the testbench at the end

    a_one_cmd : assert property (@(posedge clk) disable iff (!rst_n)
        !(mem.read && mem.write))
    else begin
        $error("read and write high in the same cycle");
        fail_count++;
    end

    // Avalon hold rule while the slave stalls
    a_hold_cmd : assert property (@(posedge clk) disable iff (!rst_n)
        (mem.read || mem.write) && waitrequest |=> $stable(mem))
    else begin
        $error("bus command changed while waitrequest was high");
        fail_count++;
    end

    a_ack_rise : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
    else begin
        $error("ack rose without a pending request");
        fail_count++;
    end

    a_be_set : assert property (@(posedge clk) disable iff (!rst_n)
        (mem.read || mem.write) |-> mem.byteenable != '0)
    else begin
        $error("bus command with no byte enabled");
        fail_count++;
    end

endmodule

bind load_store_unit load_store_unit_chk i_load_store_unit_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .ack         (ack),
    .waitrequest (waitrequest),
    .mem         (mem)
);

`default_nettype wire

/* verif/load_store_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit_tb
    import lsu_pkg::*;
();

    localparam int max_wait = 40;  // Cycles allowed per handshake phase
    localparam logic [data_w-1:0] rt_val  = 32'hA1B2_C3D4;
    localparam logic [data_w-1:0] mem_val = 32'h81F2_7344;  // Bytes 81 F2 73 44 at offsets 0..3

    typedef struct packed {
        lsu_op_e           op;
        logic [4:0]        rt;
        logic [15:0]       offset;
        logic [data_w-1:0] base;
        logic [data_w-1:0] rt_data;
        logic [data_w-1:0] mem_word;  // Preset at the target word
        logic [data_w-1:0] expected;  // Register value, or memory word after a store
    } test_t;

    logic              clk;
    logic              rst_n;
    logic              req;
    lsu_req_t          req_data;
    logic              ack;
    lsu_resp_t         resp;
    mem_cmd_t          mem;
    logic [data_w-1:0] mem_readdata = 32'hDEAD_BEEF;
    logic              waitrequest  = 1'b0;

    logic [data_w-1:0] mem_array [16];
    logic [31:0]       lcg_state  = 32'd70848;
    logic              cmd_open   = 1'b0;
    int                stall_left = 0;
    int                bus_cycles = 0;  // Cycles with read or write high
    int                errors;
    int                passed;
    int                failed;
    logic              timed_out;

    test_t tests [30] = '{
        '{op_lw,  5'd1,  16'h0014, 32'h0000_0000, rt_val, mem_val, 32'h81F2_7344},
        '{op_lb,  5'd2,  16'h0014, 32'h0000_0000, rt_val, mem_val, 32'hFFFF_FF81},
        '{op_lb,  5'd3,  16'h0015, 32'h0000_0000, rt_val, mem_val, 32'hFFFF_FFF2},
        '{op_lb,  5'd4,  16'h0016, 32'h0000_0000, rt_val, mem_val, 32'h0000_0073},
        '{op_lb,  5'd5,  16'h0017, 32'h0000_0000, rt_val, mem_val, 32'h0000_0044},
        '{op_lbu, 5'd6,  16'hFFD4, 32'h0000_0040, rt_val, mem_val, 32'h0000_0081},
        '{op_lbu, 5'd7,  16'hFFD5, 32'h0000_0040, rt_val, mem_val, 32'h0000_00F2},
        '{op_lbu, 5'd8,  16'hFFD6, 32'h0000_0040, rt_val, mem_val, 32'h0000_0073},
        '{op_lbu, 5'd9,  16'hFFD7, 32'h0000_0040, rt_val, mem_val, 32'h0000_0044},
        '{op_lh,  5'd10, 16'h0008, 32'h0000_0020, rt_val, mem_val, 32'hFFFF_81F2},
        '{op_lh,  5'd11, 16'h000A, 32'h0000_0020, rt_val, mem_val, 32'h0000_7344},
        '{op_lhu, 5'd12, 16'h0008, 32'h0000_0020, rt_val, mem_val, 32'h0000_81F2},
        '{op_lhu, 5'd13, 16'h000A, 32'h0000_0020, rt_val, mem_val, 32'h0000_7344},
        '{op_lwl, 5'd14, 16'h0000, 32'h0000_0030, rt_val, mem_val, 32'h81F2_7344},
        '{op_lwl, 5'd15, 16'h0001, 32'h0000_0030, rt_val, mem_val, 32'hF273_44D4},
        '{op_lwl, 5'd16, 16'h0002, 32'h0000_0030, rt_val, mem_val, 32'h7344_C3D4},
        '{op_lwl, 5'd17, 16'h0003, 32'h0000_0030, rt_val, mem_val, 32'h44B2_C3D4},
        '{op_lwr, 5'd18, 16'h0000, 32'h0000_0030, rt_val, mem_val, 32'hA1B2_C381},
        '{op_lwr, 5'd19, 16'h0001, 32'h0000_0030, rt_val, mem_val, 32'hA1B2_81F2},
        '{op_lwr, 5'd20, 16'h0002, 32'h0000_0030, rt_val, mem_val, 32'hA181_F273},
        '{op_lwr, 5'd21, 16'h0003, 32'h0000_0030, rt_val, mem_val, 32'h81F2_7344},
        '{op_lui, 5'd22, 16'h1234, 32'h0000_0000, rt_val, mem_val, 32'h1234_0000},
        '{op_lui, 5'd23, 16'hFEDC, 32'h0000_0010, rt_val, mem_val, 32'hFEDC_0000},
        '{op_sb,  5'd24, 16'h0000, 32'h0000_003C, rt_val, mem_val, 32'hD4F2_7344},
        '{op_sb,  5'd25, 16'h0001, 32'h0000_003C, rt_val, mem_val, 32'h81D4_7344},
        '{op_sb,  5'd26, 16'h0002, 32'h0000_003C, rt_val, mem_val, 32'h81F2_D444},
        '{op_sb,  5'd27, 16'h0003, 32'h0000_003C, rt_val, mem_val, 32'h81F2_73D4},
        '{op_sh,  5'd28, 16'h0000, 32'h0000_0008, rt_val, mem_val, 32'hC3D4_7344},
        '{op_sh,  5'd29, 16'h0002, 32'h0000_0008, rt_val, mem_val, 32'h81F2_C3D4},
        '{op_sw,  5'd30, 16'hFFFC, 32'h0000_000C, rt_val, mem_val, 32'hA1B2_C3D4}
    };

    load_store_unit i_load_store_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_data     (req_data),
        .ack          (ack),
        .resp         (resp),
        .mem          (mem),
        .mem_readdata (mem_readdata),
        .waitrequest  (waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Background word, differs for every word address
    function automatic logic [data_w-1:0] fill_word(input int i);
        return {8'hC0, 8'(i), 8'(~i), 8'(i * 7)};
    endfunction

    // Avalon slave, zero read latency, 0 to 3 stall cycles per command
    always @(negedge clk) begin : mem_model
        logic [data_w-1:0] mask;
        logic [31:0]       draw;
        if (mem.read || mem.write) begin
            bus_cycles = bus_cycles + 1;
            if (!cmd_open) begin
                cmd_open   = 1'b1;
                draw       = lcg_next();
                stall_left = int'(draw[17:16]);
            end
            if (stall_left > 0) begin
                waitrequest  = 1'b1;
                mem_readdata = 32'hDEAD_BEEF;  // Not valid until accepted
                stall_left   = stall_left - 1;
            end else begin
                waitrequest = 1'b0;
                cmd_open    = 1'b0;
                mask = {{8{mem.byteenable[3]}}, {8{mem.byteenable[2]}},
                        {8{mem.byteenable[1]}}, {8{mem.byteenable[0]}}};
                if (mem.write) begin
                    mem_array[mem.address[5:2]] = (mem_array[mem.address[5:2]] & ~mask)
                                                | (mem.writedata & mask);
                end
                // Disabled lanes return junk
                mem_readdata = mem.read ? ((mem_array[mem.address[5:2]] & mask)
                                          | (32'hDEAD_BEEF & ~mask))
                                        : 32'hDEAD_BEEF;
            end
        end else begin
            waitrequest  = 1'b0;
            mem_readdata = 32'hDEAD_BEEF;
        end
    end

    task automatic check_resp(input lsu_resp_t got, input lsu_resp_t exp, input string what);
        // wdata matters only when the register is written
        if (got.reg_we !== exp.reg_we || got.rt !== exp.rt ||
            (exp.reg_we && got.wdata !== exp.wdata)) begin
            $display("CHECK FAILED at %0t: %s got we=%b rt=%0d %h, exp we=%b rt=%0d %h",
                     $time, what, got.reg_we, got.rt, got.wdata, exp.reg_we, exp.rt, exp.wdata);
            errors++;
        end
    endtask

    task automatic check_word(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // One full four-phase transfer, called on a falling edge
    task automatic run_test(input int n, output logic ok);
        test_t             t;
        lsu_op_e           op_now;
        lsu_resp_t         exp_resp;
        logic [data_w-1:0] addr;
        logic [3:0]        idx;
        logic              store;
        int                bus_before;
        int                errors_before;
        int                wait_cnt;
        t             = tests[5'(n)];
        op_now        = t.op;
        addr          = t.base + {{16{t.offset[15]}}, t.offset};
        idx           = addr[5:2];
        store         = t.op inside {op_sb, op_sh, op_sw};
        errors_before = errors;
        ok            = 1'b1;
        for (int i = 0; i < 16; i++) begin
            mem_array[4'(i)] = fill_word(i);
        end
        mem_array[idx]   = t.mem_word;
        bus_before       = bus_cycles;
        req_data.op      = t.op;
        req_data.rt      = t.rt;
        req_data.offset  = t.offset;
        req_data.base    = t.base;
        req_data.rt_data = t.rt_data;
        req              = 1'b1;
        wait_cnt = 0;
        while (!ack && wait_cnt < max_wait) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!ack) begin
            $display("Test %0d (%s) timed out waiting for ack", n, op_now.name());
            failed++;
            ok = 1'b0;
            return;
        end
        exp_resp.reg_we = !store;
        exp_resp.rt     = t.rt;
        exp_resp.wdata  = store ? '0 : t.expected;
        check_resp(resp, exp_resp, op_now.name());
        if (store) begin
            check_word(mem_array[idx], t.expected, "memory word after store");
        end
        if (t.op == op_lui) begin
            check_word(32'(bus_cycles - bus_before), '0, "bus cycles during lui");
        end
        repeat (n % 3) begin  // Core holds req a little longer now and then
            @(negedge clk);
            if (!ack) begin
                $display("Test %0d: ack dropped at %0t while req was still high", n, $time);
                errors++;
            end
            check_resp(resp, exp_resp, "resp held under ack");
        end
        req = 1'b0;
        wait_cnt = 0;
        while (ack && wait_cnt < max_wait) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (ack) begin
            $display("Test %0d (%s) timed out waiting for ack to drop", n, op_now.name());
            failed++;
            ok = 1'b0;
            return;
        end
        if (errors == errors_before) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d %s rt %0d: %s", n, op_now.name(), t.rt,
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    initial begin : main
        logic ok;
        int   chk_fails;
        rst_n     = 1'b0;
        req       = 1'b0;
        req_data  = '0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int n = 0; n < 30; n++) begin
            run_test(n, ok);
            if (!ok) begin
                timed_out = 1'b1;
                break;
            end
        end
        chk_fails = i_load_store_unit.i_load_store_unit_chk.fail_count;
        $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
                 passed + failed, passed, failed, chk_fails);
        if (errors == 0 && chk_fails == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
